//--- hw/elink_pkg.sv
// ==============================
// Shared constants of the link controller
// Bus widths, block codes, register indices,
// writable-bit masks and the version word
// ==============================
package elink_pkg;

   localparam int DW        = 32;               // Data word width
   localparam int RFAW      = 12;               // Address width inside a block
   localparam int AW        = RFAW + 2;         // Host address, top two bits pick the block
   localparam int IDX_LSB   = 2;                // Register index sits at addr[5:2]
   localparam int IDX_W     = 4;

   localparam logic [1:0] BLK_ECFG  = 2'b00;    // Configuration registers
   localparam logic [1:0] BLK_EMBOX = 2'b01;    // Mailbox
   localparam logic [1:0] BLK_RX    = 2'b10;    // Receiver slot, reads zero
   localparam logic [1:0] BLK_TX    = 2'b11;    // Transmitter slot, reads zero

   localparam logic [IDX_W-1:0] ESYSTX      = 4'd0;
   localparam logic [IDX_W-1:0] ESYSRX      = 4'd1;
   localparam logic [IDX_W-1:0] ESYSCLK     = 4'd2;
   localparam logic [IDX_W-1:0] ESYSCOREID  = 4'd3;   // Read only
   localparam logic [IDX_W-1:0] ESYSVERSION = 4'd4;   // Read only
   localparam logic [IDX_W-1:0] ESYSDATAIN  = 4'd5;   // Read only
   localparam logic [IDX_W-1:0] ESYSDATAOUT = 4'd6;

   localparam logic [IDX_W-1:0] EMBOX_DATA   = 4'd0;  // Push on write, pop on read
   localparam logic [IDX_W-1:0] EMBOX_STATUS = 4'd1;  // Flags and count

   localparam int TX_CTRL_W  = 12;
   localparam int RX_CTRL_W  = 3;
   localparam int CLK_CTRL_W = 12;
   localparam int DATAIN_W   = 9;
   localparam int DATAOUT_W  = 11;
   localparam int COREID_W   = 12;

   localparam logic [DW-1:0] TX_MASK      = 32'h0000_0fff;  // Enable, modes, ctrl, divider
   localparam logic [DW-1:0] RX_MASK      = 32'h0000_0007;
   localparam logic [DW-1:0] CLK_MASK     = 32'h0000_0ff1;  // Bits 3:1 not implemented
   localparam logic [DW-1:0] DATAOUT_MASK = 32'h0000_07ff;

   localparam logic [DW-1:0] ELINK_VERSION = 32'h0001_0200;

endpackage

//--- hw/elink_regbus.sv
// ==============================
// Four-phase host register port
// Per-block strobe generation and read-back mux
// ==============================
`timescale 1ns/1ps

module elink_regbus import elink_pkg::*; (
   input  logic            mi_clk,
   input  logic            rst,
   // Host side
   input  logic            req,
   input  logic            we,
   input  logic [AW-1:0]   addr,
   input  logic [DW-1:0]   wdata,
   output logic            ack,
   output logic [DW-1:0]   rdata,
   // Internal register bus
   output logic [RFAW-1:0] mi_addr,
   output logic [DW-1:0]   mi_din,
   output logic            mi_we,
   output logic            ecfg_en,
   output logic            embox_en,
   input  logic [DW-1:0]   ecfg_dout,
   input  logic [DW-1:0]   embox_dout
);

   localparam logic [1:0] S_IDLE    = 2'd0;   // Waiting for req
   localparam logic [1:0] S_ACCESS  = 2'd1;   // Strobe cycle
   localparam logic [1:0] S_ACKWAIT = 2'd2;   // Ack raised, waiting for req low

   logic [1:0]    state;
   logic [1:0]    blk_sel;   // Latched addr[13:12]
   logic [DW-1:0] rd_mux;
   logic [DW-1:0] rd_hold;   // Read data caught at the strobe edge

   // Handshake FSM
   always_ff @(posedge mi_clk) begin
      if (rst) begin
         state <= S_IDLE;
         ack   <= 1'b0;
         rdata <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (req) state <= S_ACCESS;   // One access per request
            end
            S_ACCESS: begin
               state <= S_ACKWAIT;
            end
            S_ACKWAIT: begin
               if (!ack) begin
                  ack   <= 1'b1;              // Two edges after req sampled
                  rdata <= rd_hold;
               end else if (!req) begin
                  ack   <= 1'b0;              // Host released, back to idle
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Request payload, held stable through the access
   always_ff @(posedge mi_clk) begin
      if (state == S_IDLE && req) begin
         mi_addr <= addr[RFAW-1:0];
         blk_sel <= addr[AW-1:RFAW];
         mi_we   <= we;
         mi_din  <= wdata;
      end
      if (state == S_ACCESS)
         rd_hold <= rd_mux;               // Before a mailbox pop moves the head
   end

   // Single-cycle strobes, none for the rx and tx slots
   assign ecfg_en  = (state == S_ACCESS) && (blk_sel == BLK_ECFG);
   assign embox_en = (state == S_ACCESS) && (blk_sel == BLK_EMBOX);

   always_comb begin
      case (blk_sel)
         BLK_ECFG:  rd_mux = ecfg_dout;
         BLK_EMBOX: rd_mux = embox_dout;
         default:   rd_mux = '0;          // BLK_RX and BLK_TX read zero
      endcase
   end

endmodule

//--- hw/ecfg_regs.sv
// ==============================
// Link configuration register file
// Masked writes, read-back mux, registered
// control outputs
// ==============================
`timescale 1ns/1ps

module ecfg_regs import elink_pkg::*; #(
   parameter logic [COREID_W-1:0] COREID = 12'h810
) (
   input  logic                  mi_clk,
   input  logic                  rst,
   input  logic                  mi_en,
   input  logic                  mi_we,
   input  logic [RFAW-1:0]       mi_addr,
   input  logic [DW-1:0]         mi_din,
   output logic [DW-1:0]         mi_dout,
   input  logic [DATAIN_W-1:0]   datain,
   output logic [TX_CTRL_W-1:0]  ecfg_tx_ctrl,
   output logic [RX_CTRL_W-1:0]  ecfg_rx_ctrl,
   output logic [CLK_CTRL_W-1:0] ecfg_clk_ctrl,
   output logic [DATAOUT_W-1:0]  dataout
);

   logic [IDX_W-1:0]      idx;
   logic                  wr_en;
   logic [TX_CTRL_W-1:0]  tx_reg;      // Enable, mmu, gpio, tp, ctrl mode, divider
   logic [RX_CTRL_W-1:0]  rx_reg;      // Enable, mmu, gpio
   logic [CLK_CTRL_W-1:0] clk_reg;     // cclk enable, divider, pll config
   logic [DATAOUT_W-1:0]  dataout_reg;

   assign idx   = mi_addr[IDX_LSB +: IDX_W];
   assign wr_en = mi_en && mi_we;

   // Register writes, masked to implemented bits
   always_ff @(posedge mi_clk) begin
      if (rst) begin
         tx_reg      <= '0;
         rx_reg      <= '0;
         clk_reg     <= '0;
         dataout_reg <= '0;
      end else if (wr_en) begin
         case (idx)
            ESYSTX:
               tx_reg <= mi_din[TX_CTRL_W-1:0] & TX_MASK[TX_CTRL_W-1:0];
            ESYSRX:
               rx_reg <= mi_din[RX_CTRL_W-1:0] & RX_MASK[RX_CTRL_W-1:0];
            ESYSCLK:
               clk_reg <= mi_din[CLK_CTRL_W-1:0] & CLK_MASK[CLK_CTRL_W-1:0];
            ESYSDATAOUT:
               dataout_reg <= mi_din[DATAOUT_W-1:0] & DATAOUT_MASK[DATAOUT_W-1:0];
            default: ;                  // Read-only and unused indices
         endcase
      end
   end

   // Control outputs follow the registers one cycle later
   always_ff @(posedge mi_clk) begin
      if (rst) begin
         ecfg_tx_ctrl  <= '0;
         ecfg_rx_ctrl  <= '0;
         ecfg_clk_ctrl <= '0;
         dataout       <= '0;
      end else begin
         ecfg_tx_ctrl  <= tx_reg;
         ecfg_rx_ctrl  <= rx_reg;
         ecfg_clk_ctrl <= clk_reg;
         dataout       <= dataout_reg;
      end
   end

   // Read-back, valid while the strobe is up
   always_comb begin
      case (idx)
         ESYSTX:      mi_dout = DW'(tx_reg);
         ESYSRX:      mi_dout = DW'(rx_reg);
         ESYSCLK:     mi_dout = DW'(clk_reg);
         ESYSCOREID:  mi_dout = DW'(COREID);
         ESYSVERSION: mi_dout = ELINK_VERSION;
         ESYSDATAIN:  mi_dout = DW'(datain);     // Live gpio input
         ESYSDATAOUT: mi_dout = DW'(dataout_reg);
         default:     mi_dout = '0;
      endcase
   end

endmodule

//--- hw/embox_fifo.sv
// ==============================
// Mailbox word FIFO
// Registered flags and status register
// ==============================
`timescale 1ns/1ps

module embox_fifo import elink_pkg::*; #(
   parameter int MBOX_DEPTH = 16                // Power of two
) (
   input  logic            mi_clk,
   input  logic            rst,
   input  logic            mi_en,
   input  logic            mi_we,
   input  logic [RFAW-1:0] mi_addr,
   input  logic [DW-1:0]   mi_din,
   output logic [DW-1:0]   mi_dout,
   output logic            embox_not_empty,
   output logic            embox_full
);

   localparam int PTR_W = $clog2(MBOX_DEPTH);

   logic [DW-1:0]    mem [MBOX_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;       // Holds 0 to MBOX_DEPTH
   logic [PTR_W:0]   count_nxt;
   logic [IDX_W-1:0] idx;
   logic             push;
   logic             pop;

   assign idx  = mi_addr[IDX_LSB +: IDX_W];
   assign push = mi_en && mi_we && (idx == EMBOX_DATA) && !embox_full;     // Full drops word
   assign pop  = mi_en && !mi_we && (idx == EMBOX_DATA) && embox_not_empty;

   always_comb begin
      count_nxt = count;
      if (push)
         count_nxt = count + 1'b1;
      else if (pop)
         count_nxt = count - 1'b1;
   end

   // Pointers, count and flags, all moving at the strobe edge
   always_ff @(posedge mi_clk) begin
      if (rst) begin
         wr_ptr          <= '0;
         rd_ptr          <= '0;
         count           <= '0;
         embox_not_empty <= 1'b0;
         embox_full      <= 1'b0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;   // Wraps with power-of-two depth
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         count           <= count_nxt;
         embox_not_empty <= (count_nxt != '0);
         embox_full      <= (count_nxt == (PTR_W+1)'(MBOX_DEPTH));
      end
   end

   always_ff @(posedge mi_clk) begin
      if (push) mem[wr_ptr] <= mi_din;
   end

   // Head word or status, zero when nothing to pop
   always_comb begin
      mi_dout = '0;
      case (idx)
         EMBOX_DATA: begin
            if (embox_not_empty) mi_dout = mem[rd_ptr];
         end
         EMBOX_STATUS: begin
            mi_dout[0]    = embox_not_empty;
            mi_dout[1]    = embox_full;
            mi_dout[15:8] = 8'(count);
         end
         default: ;
      endcase
   end

endmodule

//--- hw/elink_top.sv
// ==============================
// Link controller configuration top
// Register port, config registers, mailbox
// ==============================
`timescale 1ns/1ps

module elink_top import elink_pkg::*; #(
   parameter logic [COREID_W-1:0] COREID     = 12'h810,
   parameter int                  MBOX_DEPTH = 16
) (
   input  logic                  mi_clk,
   input  logic                  rst,
   input  logic                  req,
   input  logic                  we,
   input  logic [AW-1:0]         addr,
   input  logic [DW-1:0]         wdata,
   output logic                  ack,
   output logic [DW-1:0]         rdata,
   input  logic [DATAIN_W-1:0]   datain,
   output logic [TX_CTRL_W-1:0]  ecfg_tx_ctrl,
   output logic [RX_CTRL_W-1:0]  ecfg_rx_ctrl,
   output logic [CLK_CTRL_W-1:0] ecfg_clk_ctrl,
   output logic [DATAOUT_W-1:0]  dataout,
   output logic                  embox_not_empty,
   output logic                  embox_full
);

   logic [RFAW-1:0] mi_addr;
   logic [DW-1:0]   mi_din;
   logic            mi_we;
   logic            ecfg_en;      // Strobe into config block
   logic            embox_en;     // Strobe into mailbox
   logic [DW-1:0]   ecfg_dout;
   logic [DW-1:0]   embox_dout;

   elink_regbus u_regbus (
      .mi_clk     (mi_clk),
      .rst        (rst),
      .req        (req),
      .we         (we),
      .addr       (addr),
      .wdata      (wdata),
      .ack        (ack),
      .rdata      (rdata),
      .mi_addr    (mi_addr),
      .mi_din     (mi_din),
      .mi_we      (mi_we),
      .ecfg_en    (ecfg_en),
      .embox_en   (embox_en),
      .ecfg_dout  (ecfg_dout),
      .embox_dout (embox_dout)
   );

   ecfg_regs #(.COREID(COREID)) u_ecfg (
      .mi_clk        (mi_clk),
      .rst           (rst),
      .mi_en         (ecfg_en),
      .mi_we         (mi_we),
      .mi_addr       (mi_addr),
      .mi_din        (mi_din),
      .mi_dout       (ecfg_dout),
      .datain        (datain),
      .ecfg_tx_ctrl  (ecfg_tx_ctrl),
      .ecfg_rx_ctrl  (ecfg_rx_ctrl),
      .ecfg_clk_ctrl (ecfg_clk_ctrl),
      .dataout       (dataout)
   );

   embox_fifo #(.MBOX_DEPTH(MBOX_DEPTH)) u_embox (
      .mi_clk          (mi_clk),
      .rst             (rst),
      .mi_en           (embox_en),
      .mi_we           (mi_we),
      .mi_addr         (mi_addr),
      .mi_din          (mi_din),
      .mi_dout         (embox_dout),
      .embox_not_empty (embox_not_empty),
      .embox_full      (embox_full)
   );

endmodule

//--- sim/elink_props.sv
// ==============================
// Handshake, strobe and mailbox flag
// assertions, bound to the top
// ==============================
`timescale 1ns/1ps

module elink_props (
   input logic mi_clk,
   input logic rst,
   input logic req,
   input logic ack,
   input logic ecfg_en,
   input logic embox_en,
   input logic embox_not_empty,
   input logic embox_full
);

   // Ack only answers a live request
   assert property (@(posedge mi_clk) disable iff (rst) $rose(ack) |-> req)
      else $error("ack rose while req was low");

   // Held until the host lets go
   assert property (@(posedge mi_clk) disable iff (rst) (ack && req) |=> ack)
      else $error("ack fell while req was still high");

   assert property (@(posedge mi_clk) disable iff (rst) !(ecfg_en && embox_en))
      else $error("ecfg and embox strobes high together");

   // Full implies something stored
   assert property (@(posedge mi_clk) disable iff (rst) embox_full |-> embox_not_empty)
      else $error("embox_full set with an empty FIFO");

endmodule

bind elink_top elink_props u_props (
   .mi_clk          (mi_clk),
   .rst             (rst),
   .req             (req),
   .ack             (ack),
   .ecfg_en         (ecfg_en),
   .embox_en        (embox_en),
   .embox_not_empty (embox_not_empty),
   .embox_full      (embox_full)
);

//--- sim/elink_tb.sv
// ==============================
// Testbench for the link controller top
// Clock, reset, LFSR, reference model,
// compare tasks, watchdog and tests
// ==============================
`timescale 1ns/1ps

module elink_tb import elink_pkg::*; ();

   localparam logic [COREID_W-1:0] TB_COREID = 12'ha5c;
   localparam int TB_DEPTH      = 16;
   localparam int RESET_CYCLES  = 16;
   // Accesses per test, in test order
   localparam int MAX_ACCESSES  = 2 + 3 * 8 + 28 + (3 * TB_DEPTH + 5) + 14 + 7;
   localparam int WATCHDOG_NS   = (MAX_ACCESSES * 10 + RESET_CYCLES) * 20;

   logic                  mi_clk;
   logic                  rst     = 1'b1;
   logic                  req     = 1'b0;
   logic                  we      = 1'b0;
   logic [AW-1:0]         addr    = '0;
   logic [DW-1:0]         wdata   = '0;
   logic [DATAIN_W-1:0]   datain  = '0;
   logic                  ack;
   logic [DW-1:0]         rdata;
   logic [TX_CTRL_W-1:0]  ecfg_tx_ctrl;
   logic [RX_CTRL_W-1:0]  ecfg_rx_ctrl;
   logic [CLK_CTRL_W-1:0] ecfg_clk_ctrl;
   logic [DATAOUT_W-1:0]  dataout;
   logic                  embox_not_empty;
   logic                  embox_full;

   logic [31:0]         lfsr_state = 32'hd859;
   logic [DW-1:0]       shadow_tx, shadow_rx, shadow_clk, shadow_dout;
   logic [DATAIN_W-1:0] datain_val;
   logic [DW-1:0]       mbox_q[$];   // Mailbox model, head at index 0
   int err_count  = 0;
   int test_errs0 = 0;
   int tests_run  = 0;
   int tests_bad  = 0;

   elink_top #(.COREID(TB_COREID), .MBOX_DEPTH(TB_DEPTH)) uut (.*);

   initial begin
      mi_clk = 1'b0;
      forever #10 mi_clk = ~mi_clk;   // 20 ns period
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("SIMULATION FAILED");
      $finish;
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [DW-1:0] rand_bits(input int nbits);
      logic [DW-1:0] w;
      w = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr_state = lfsr_next(lfsr_state);   // One step per bit
         w = {w[DW-2:0], lfsr_state[0]};
      end
      return w;
   endfunction

   function automatic logic [AW-1:0] mk_addr(input logic [1:0] blk, input logic [IDX_W-1:0] idx);
      return {blk, {(RFAW - IDX_W - IDX_LSB){1'b0}}, idx, {IDX_LSB{1'b0}}};
   endfunction

   // Expected read value from the shadows and the mailbox model
   function automatic logic [DW-1:0] exp_read(input logic [1:0] blk, input logic [IDX_W-1:0] idx);
      logic [DW-1:0] st;
      st = '0;
      if (blk == BLK_ECFG) begin
         case (idx)
            ESYSTX:      return shadow_tx;
            ESYSRX:      return shadow_rx;
            ESYSCLK:     return shadow_clk;
            ESYSCOREID:  return DW'(TB_COREID);
            ESYSVERSION: return ELINK_VERSION;
            ESYSDATAIN:  return DW'(datain_val);
            ESYSDATAOUT: return shadow_dout;
            default:     return '0;
         endcase
      end else if (blk == BLK_EMBOX) begin
         if (idx == EMBOX_DATA)
            return (mbox_q.size() != 0) ? mbox_q[0] : '0;   // Empty reads zero
         if (idx == EMBOX_STATUS) begin
            st[0]     = (mbox_q.size() != 0);
            st[1]     = (mbox_q.size() == TB_DEPTH);
            st[15:8]  = 8'(mbox_q.size());
         end
         return st;
      end
      return '0;                                             // Rx and tx slots
   endfunction

   task automatic model_update(input logic wr, input logic [1:0] blk,
                               input logic [IDX_W-1:0] idx, input logic [DW-1:0] d);
      if (wr && blk == BLK_ECFG) begin
         case (idx)
            ESYSTX:      shadow_tx   = d & TX_MASK;
            ESYSRX:      shadow_rx   = d & RX_MASK;
            ESYSCLK:     shadow_clk  = d & CLK_MASK;
            ESYSDATAOUT: shadow_dout = d & DATAOUT_MASK;
            default: ;
         endcase
      end else if (blk == BLK_EMBOX && idx == EMBOX_DATA) begin
         if (wr && mbox_q.size() < TB_DEPTH)
            mbox_q.push_back(d);                             // Full drops the word
         else if (!wr && mbox_q.size() != 0)
            void'(mbox_q.pop_front());
      end
   endtask

   task automatic check_word(input string what, input logic [DW-1:0] got,
                             input logic [DW-1:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
         err_count++;
      end
   endtask

   task automatic check_ctrl(input string what, input logic [TX_CTRL_W-1:0] got,
                             input logic [TX_CTRL_W-1:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
         err_count++;
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s got %b expected %b", $time, what, got, exp);
         err_count++;
      end
   endtask

   task automatic check_outputs();
      check_ctrl("ecfg_tx_ctrl", ecfg_tx_ctrl, shadow_tx[TX_CTRL_W-1:0]);
      check_ctrl("ecfg_rx_ctrl", TX_CTRL_W'(ecfg_rx_ctrl), shadow_rx[TX_CTRL_W-1:0]);
      check_ctrl("ecfg_clk_ctrl", ecfg_clk_ctrl, shadow_clk[TX_CTRL_W-1:0]);
      check_ctrl("dataout", TX_CTRL_W'(dataout), shadow_dout[TX_CTRL_W-1:0]);
      check_flag("embox_not_empty", embox_not_empty, mbox_q.size() != 0);
      check_flag("embox_full", embox_full, mbox_q.size() == TB_DEPTH);
   endtask

   // Full four-phase access, reads compared against the model
   task automatic bus_access(input logic wr, input logic [1:0] blk, input logic [IDX_W-1:0] idx,
                             input logic [DW-1:0] d, input int hold_cycles);
      logic [DW-1:0] exp;
      logic [DW-1:0] got;
      exp = exp_read(blk, idx);
      @(posedge mi_clk);
      req   <= 1'b1;
      we    <= wr;
      addr  <= mk_addr(blk, idx);
      wdata <= d;
      do @(posedge mi_clk); while (!ack);
      got = rdata;
      repeat (hold_cycles) begin
         @(posedge mi_clk);
         check_flag("ack while req held", ack, 1'b1);
      end
      req <= 1'b0;
      do @(posedge mi_clk); while (ack);
      model_update(wr, blk, idx, d);
      if (!wr)
         check_word($sformatf("read blk %0d idx %0d", blk, idx), got, exp);
   endtask

   task automatic start_test();
      test_errs0 = err_count;
   endtask

   task automatic end_test(input string name);
      int errs;
      errs = err_count - test_errs0;
      tests_run++;
      if (errs != 0) tests_bad++;
      $display("test %0d %s: %s (%0d errors)", tests_run, name,
               (errs == 0) ? "ok" : "bad", errs);
   endtask

   initial begin
      logic [DW-1:0] r;
      shadow_tx   = '0;
      shadow_rx   = '0;
      shadow_clk  = '0;
      shadow_dout = '0;
      datain_val  = '0;
      repeat (RESET_CYCLES) @(posedge mi_clk);
      rst <= 1'b0;
      @(posedge mi_clk);

      start_test();                                   // Reset state and ids
      check_flag("ack", ack, 1'b0);
      check_outputs();
      bus_access(1'b0, BLK_ECFG, ESYSCOREID, '0, 0);
      bus_access(1'b0, BLK_ECFG, ESYSVERSION, '0, 0);
      end_test("reset and ids");

      start_test();
      for (int k = 0; k < 3; k++) begin
         bus_access(1'b1, BLK_ECFG, ESYSTX, rand_bits(DW), 0);
         bus_access(1'b0, BLK_ECFG, ESYSTX, '0, 0);
         bus_access(1'b1, BLK_ECFG, ESYSRX, rand_bits(DW), 0);
         bus_access(1'b0, BLK_ECFG, ESYSRX, '0, 0);
         bus_access(1'b1, BLK_ECFG, ESYSCLK, rand_bits(DW), 0);
         bus_access(1'b0, BLK_ECFG, ESYSCLK, '0, 0);
         bus_access(1'b1, BLK_ECFG, ESYSDATAOUT, rand_bits(DW), 0);
         bus_access(1'b0, BLK_ECFG, ESYSDATAOUT, '0, 0);
         check_outputs();
      end
      end_test("masked config writes");

      start_test();
      @(posedge mi_clk);
      r = rand_bits(DATAIN_W);
      datain     <= r[DATAIN_W-1:0];
      datain_val  = r[DATAIN_W-1:0];
      for (int i = 3; i < 16; i++)
         if (i != 6) bus_access(1'b1, BLK_ECFG, IDX_W'(i), rand_bits(DW), 0);
      for (int i = 0; i < 16; i++)
         bus_access(1'b0, BLK_ECFG, IDX_W'(i), '0, 0);
      check_outputs();
      end_test("datain and read-only");

      start_test();
      bus_access(1'b0, BLK_EMBOX, EMBOX_STATUS, '0, 0);
      for (int i = 0; i < TB_DEPTH; i++) begin
         bus_access(1'b1, BLK_EMBOX, EMBOX_DATA, rand_bits(DW), 0);
         bus_access(1'b0, BLK_EMBOX, EMBOX_STATUS, '0, 0);
      end
      check_flag("embox_full after fill", embox_full, 1'b1);
      bus_access(1'b1, BLK_EMBOX, EMBOX_DATA, rand_bits(DW), 0);   // Dropped
      bus_access(1'b0, BLK_EMBOX, EMBOX_STATUS, '0, 0);
      for (int i = 0; i < TB_DEPTH; i++)
         bus_access(1'b0, BLK_EMBOX, EMBOX_DATA, '0, 0);
      check_outputs();
      bus_access(1'b0, BLK_EMBOX, EMBOX_DATA, '0, 0);              // Empty
      bus_access(1'b0, BLK_EMBOX, EMBOX_STATUS, '0, 0);
      end_test("mailbox fifo");

      start_test();
      bus_access(1'b1, BLK_EMBOX, EMBOX_DATA, rand_bits(DW), 0);
      bus_access(1'b1, BLK_RX, 4'd0, rand_bits(DW), 0);
      bus_access(1'b1, BLK_TX, 4'd0, rand_bits(DW), 0);
      bus_access(1'b1, BLK_TX, 4'd6, rand_bits(DW), 0);
      bus_access(1'b0, BLK_RX, 4'd0, '0, 0);
      bus_access(1'b0, BLK_TX, 4'd1, '0, 0);
      for (int i = 0; i < 7; i++)
         bus_access(1'b0, BLK_ECFG, IDX_W'(i), '0, 0);
      bus_access(1'b0, BLK_EMBOX, EMBOX_STATUS, '0, 0);
      check_outputs();
      end_test("rx and tx slots");

      start_test();
      bus_access(1'b1, BLK_EMBOX, EMBOX_DATA, rand_bits(DW), 0);
      bus_access(1'b1, BLK_EMBOX, EMBOX_DATA, rand_bits(DW), 0);
      bus_access(1'b0, BLK_EMBOX, EMBOX_DATA, '0, 5);              // Held req
      bus_access(1'b0, BLK_EMBOX, EMBOX_STATUS, '0, 0);
      bus_access(1'b0, BLK_EMBOX, EMBOX_DATA, '0, 3);
      bus_access(1'b0, BLK_EMBOX, EMBOX_DATA, '0, 0);
      bus_access(1'b0, BLK_EMBOX, EMBOX_STATUS, '0, 0);
      check_outputs();
      end_test("held request");

      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_bad, err_count);
      if (err_count == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

//--- all.f
hw/elink_pkg.sv
hw/elink_regbus.sv
hw/ecfg_regs.sv
hw/embox_fifo.sv
hw/elink_top.sv
sim/elink_props.sv
sim/elink_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and check the log for the pass line

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Mdir obj_dir \
   --top-module elink_tb -f all.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Velink_tb > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^SIMULATION PASSED$" "$SIM_LOG"; then
   exit 0
fi
echo "Pass line not found in $SIM_LOG"
exit 1
